//--- include/qnet_settings.svh
`ifndef QNET_SETTINGS_SVH
`define QNET_SETTINGS_SVH

`default_nettype none

//////////////////////////////////////////////////
// Command format widths
//////////////////////////////////////////////////
`define QNET_TIME_W 48   // Absolute time
`define QNET_DATA_W 32   // Command data word and parameters
`define QNET_OP_W   5    // Opcode field

//////////////////////////////////////////////////
// Limits
//////////////////////////////////////////////////
`define QNET_ERR_W  4    // Late command counter, saturates

`default_nettype wire

`endif

//--- hw/qnet_pkg.sv
`include "qnet_settings.svh"
`default_nettype none

package qnet_pkg;

   // Processor opcodes
   typedef enum logic [`QNET_OP_W-1:0] {
      OP_NOP        = 5'd0,
      OP_SET_OFF    = 5'd1,   // Time offset
      OP_SET_RTD    = 5'd2,   // Round trip delay
      OP_SET_DT1    = 5'd3,
      OP_SET_DT2    = 5'd4,
      OP_TIME_RST   = 5'd5,
      OP_TIME_INIT  = 5'd6,
      OP_TIME_UPDT  = 5'd7,
      OP_START_CORE = 5'd8,   // Scheduled at absolute time
      OP_STOP_CORE  = 5'd9
   } qnet_op_e;

   // Timed start/stop FSM
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_CHECK = 2'd1,   // RTD margin test
      ST_WAIT  = 2'd2,
      ST_FIRE  = 2'd3
   } sched_state_e;

endpackage

`default_nettype wire

//--- hw/qnet_cmd_decode.sv
`include "qnet_settings.svh"
`default_nettype none

module qnet_cmd_decode
   import qnet_pkg::*;
(
   input  logic                    t_clk_i,
   input  logic                    ps_rst_ni,
   input  logic                    c_cmd_i,
   input  qnet_op_e                c_op_i,
   input  logic [`QNET_DATA_W-1:0] c_dt1_i,
   input  logic [`QNET_DATA_W-1:0] c_dt2_i,
   input  logic                    sched_busy_i,
   output logic                    c_ready_o,
   output logic                    op_vld_o,
   output qnet_op_e                op_o,
   output logic [`QNET_DATA_W-1:0] dt1_o,
   output logic [`QNET_DATA_W-1:0] dt2_o,
   output logic                    time_rst_o,
   output logic                    time_init_o,
   output logic                    time_updt_o
);

   logic pend_q;     // Second cycle of a taken command
   logic cmd_take;

   // Busy while a command is in flight or a timed op is scheduled
   assign c_ready_o = ~op_vld_o & ~pend_q & ~sched_busy_i;
   assign cmd_take  = c_cmd_i & c_ready_o;

   //////////////////////////////////////////////////
   // Command capture
   //////////////////////////////////////////////////
   always_ff @(posedge t_clk_i or negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         op_vld_o <= 1'b0;
         pend_q   <= 1'b0;
         op_o     <= OP_NOP;
         dt1_o    <= '0;
         dt2_o    <= '0;
      end else begin
         op_vld_o <= cmd_take;
         pend_q   <= op_vld_o;
         if (cmd_take) begin
            op_o  <= c_op_i;
            dt1_o <= c_dt1_i;
            dt2_o <= c_dt2_i;
         end
      end
   end

   //////////////////////////////////////////////////
   // Time base pulses
   //////////////////////////////////////////////////
   always_ff @(posedge t_clk_i or negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         time_rst_o  <= 1'b0;
         time_init_o <= 1'b0;
         time_updt_o <= 1'b0;
      end else begin
         time_rst_o  <= op_vld_o & (op_o == OP_TIME_RST);
         time_init_o <= op_vld_o & (op_o == OP_TIME_INIT);
         time_updt_o <= op_vld_o & (op_o == OP_TIME_UPDT);   // One cycle only
      end
   end

endmodule

`default_nettype wire

//--- hw/qnet_param_regs.sv
`include "qnet_settings.svh"
`default_nettype none

module qnet_param_regs
   import qnet_pkg::*;
(
   input  logic                    t_clk_i,
   input  logic                    ps_rst_ni,
   input  logic                    op_vld_i,
   input  qnet_op_e                op_i,
   input  logic [`QNET_DATA_W-1:0] dt1_i,
   output logic [`QNET_DATA_W-1:0] rtd_o,
   output logic [`QNET_DATA_W-1:0] time_off_dt_o,
   output logic [`QNET_DATA_W-1:0] tnet_dt1_o,
   output logic [`QNET_DATA_W-1:0] tnet_dt2_o
);

   //////////////////////////////////////////////////
   // Network parameters
   //////////////////////////////////////////////////

   // Each SET opcode owns one register, data always from dt1
   always_ff @(posedge t_clk_i or negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         rtd_o         <= '0;
         time_off_dt_o <= '0;
         tnet_dt1_o    <= '0;
         tnet_dt2_o    <= '0;
      end else if (op_vld_i) begin
         case (op_i)
            OP_SET_OFF: begin
               time_off_dt_o <= dt1_i;
            end
            OP_SET_RTD: begin
               rtd_o <= dt1_i;      // Used by the late check
            end
            OP_SET_DT1: begin
               tnet_dt1_o <= dt1_i;
            end
            OP_SET_DT2: begin
               tnet_dt2_o <= dt1_i;
            end
            default: begin
               // TIME and START/STOP handled elsewhere
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/qnet_ctrl_sched.sv
`include "qnet_settings.svh"
`default_nettype none

module qnet_ctrl_sched
   import qnet_pkg::*;
(
   input  logic                    t_clk_i,
   input  logic                    ps_rst_ni,
   input  logic                    op_vld_i,
   input  qnet_op_e                op_i,
   input  logic [`QNET_DATA_W-1:0] dt1_i,
   input  logic [`QNET_DATA_W-1:0] dt2_i,
   input  logic [`QNET_TIME_W-1:0] t_time_abs_i,
   input  logic [`QNET_DATA_W-1:0] rtd_i,
   output logic                    sched_busy_o,
   output logic                    core_start_o,
   output logic                    core_stop_o,
   output logic [`QNET_ERR_W-1:0]  ctrl_err_cnt_o
);

   sched_state_e state_q;

   logic [`QNET_TIME_W-1:0] target_q;
   logic                    stop_q;     // Remembered action, 1 for stop
   logic [`QNET_TIME_W:0]   rem_q;      // Signed time left
   logic [`QNET_TIME_W:0]   rem_now;
   logic [`QNET_TIME_W+1:0] slack;
   logic                    late;
   logic                    due;
   logic                    timed_op;

   //////////////////////////////////////////////////
   // Time arithmetic
   //////////////////////////////////////////////////
   assign rem_now = {1'b0, target_q} - {1'b0, t_time_abs_i};
   assign slack   = {rem_now[`QNET_TIME_W], rem_now}
                  - {{(`QNET_TIME_W+2-`QNET_DATA_W){1'b0}}, rtd_i};
   assign late    = slack[`QNET_TIME_W+1];     // Less than RTD left
   assign due     = rem_q[`QNET_TIME_W] | (rem_q == '0);

   assign timed_op     = (op_i == OP_START_CORE) | (op_i == OP_STOP_CORE);
   assign sched_busy_o = (state_q != ST_IDLE);

   //////////////////////////////////////////////////
   // Scheduler FSM
   //////////////////////////////////////////////////
   always_ff @(posedge t_clk_i or negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         state_q        <= ST_IDLE;
         target_q       <= '0;
         stop_q         <= 1'b0;
         rem_q          <= '0;
         core_start_o   <= 1'b0;
         core_stop_o    <= 1'b0;
         ctrl_err_cnt_o <= '0;
      end else begin
         core_start_o <= 1'b0;
         core_stop_o  <= 1'b0;
         case (state_q)
            ST_IDLE: begin
               if (op_vld_i && timed_op) begin
                  // Target is dt2 low bits above dt1
                  target_q <= {dt2_i[`QNET_TIME_W-`QNET_DATA_W-1:0], dt1_i};
                  stop_q   <= (op_i == OP_STOP_CORE);
                  state_q  <= ST_CHECK;
               end
            end
            ST_CHECK: begin
               rem_q <= rem_now;
               if (late) begin
                  if (ctrl_err_cnt_o != '1) begin
                     ctrl_err_cnt_o <= ctrl_err_cnt_o + 1'b1;   // Saturating
                  end
                  state_q <= ST_IDLE;
               end else begin
                  state_q <= ST_WAIT;
               end
            end
            ST_WAIT: begin
               rem_q <= rem_now;
               if (due) begin
                  core_start_o <= ~stop_q;
                  core_stop_o  <= stop_q;
                  state_q      <= ST_FIRE;
               end
            end
            ST_FIRE: begin
               // Pulse is high during this state
               state_q <= ST_IDLE;
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/qnet_ctrl_top.sv
`include "qnet_settings.svh"
`default_nettype none

module qnet_ctrl_top
   import qnet_pkg::*;
(
   input  logic                    t_clk_i,
   input  logic                    ps_rst_ni,
   input  logic                    c_cmd_i,
   input  qnet_op_e                c_op_i,
   input  logic [`QNET_DATA_W-1:0] c_dt1_i,
   input  logic [`QNET_DATA_W-1:0] c_dt2_i,
   input  logic [`QNET_TIME_W-1:0] t_time_abs_i,
   output logic                    c_ready_o,
   output logic                    time_rst_o,
   output logic                    time_init_o,
   output logic                    time_updt_o,
   output logic [`QNET_DATA_W-1:0] time_off_dt_o,
   output logic [`QNET_DATA_W-1:0] tnet_dt1_o,
   output logic [`QNET_DATA_W-1:0] tnet_dt2_o,
   output logic                    core_start_o,
   output logic                    core_stop_o,
   output logic [`QNET_ERR_W-1:0]  ctrl_err_cnt_o
);

   logic                    op_vld;
   qnet_op_e                op;
   logic [`QNET_DATA_W-1:0] dt1;
   logic [`QNET_DATA_W-1:0] dt2;
   logic [`QNET_DATA_W-1:0] rtd;
   logic                    sched_busy;   // Holds off new commands

   //////////////////////////////////////////////////
   // Command decode
   //////////////////////////////////////////////////
   qnet_cmd_decode u_decode (
      .t_clk_i      (t_clk_i),
      .ps_rst_ni    (ps_rst_ni),
      .c_cmd_i      (c_cmd_i),
      .c_op_i       (c_op_i),
      .c_dt1_i      (c_dt1_i),
      .c_dt2_i      (c_dt2_i),
      .sched_busy_i (sched_busy),
      .c_ready_o    (c_ready_o),
      .op_vld_o     (op_vld),
      .op_o         (op),
      .dt1_o        (dt1),
      .dt2_o        (dt2),
      .time_rst_o   (time_rst_o),
      .time_init_o  (time_init_o),
      .time_updt_o  (time_updt_o)
   );

   qnet_param_regs u_params (
      .t_clk_i       (t_clk_i),
      .ps_rst_ni     (ps_rst_ni),
      .op_vld_i      (op_vld),
      .op_i          (op),
      .dt1_i         (dt1),
      .rtd_o         (rtd),
      .time_off_dt_o (time_off_dt_o),
      .tnet_dt1_o    (tnet_dt1_o),
      .tnet_dt2_o    (tnet_dt2_o)
   );

   // Timed core start and stop
   qnet_ctrl_sched u_sched (
      .t_clk_i        (t_clk_i),
      .ps_rst_ni      (ps_rst_ni),
      .op_vld_i       (op_vld),
      .op_i           (op),
      .dt1_i          (dt1),
      .dt2_i          (dt2),
      .t_time_abs_i   (t_time_abs_i),
      .rtd_i          (rtd),
      .sched_busy_o   (sched_busy),
      .core_start_o   (core_start_o),
      .core_stop_o    (core_stop_o),
      .ctrl_err_cnt_o (ctrl_err_cnt_o)
   );

endmodule

`default_nettype wire

//--- verif/qnet_ctrl_assert.sv
`default_nettype none

module qnet_ctrl_assert (
   input logic t_clk_i,
   input logic ps_rst_ni,
   input logic c_cmd_i,
   input logic c_ready_i,
   input logic time_rst_i,
   input logic time_init_i,
   input logic time_updt_i,
   input logic core_start_i,
   input logic core_stop_i
);

   int fail_cnt = 0;   // Failed assertions so far

   //////////////////////////////////////////////////
   // Pulse exclusivity
   //////////////////////////////////////////////////
   time_excl_a: assert property (@(posedge t_clk_i) disable iff (!ps_rst_ni)
      $onehot0({time_rst_i, time_init_i, time_updt_i}))
      else begin
         $error("time base pulses overlap");
         fail_cnt = fail_cnt + 1;
      end

   core_excl_a: assert property (@(posedge t_clk_i) disable iff (!ps_rst_ni)
      !(core_start_i && core_stop_i))
      else begin
         $error("core start and stop high together");
         fail_cnt = fail_cnt + 1;
      end

   // Accepted command blocks the next one
   ready_drop_a: assert property (@(posedge t_clk_i) disable iff (!ps_rst_ni)
      (c_cmd_i && c_ready_i) |=> !c_ready_i)
      else begin
         $error("c_ready_o stayed high after an accepted command");
         fail_cnt = fail_cnt + 1;
      end

   pulse_width_a: assert property (@(posedge t_clk_i) disable iff (!ps_rst_ni)
      (time_rst_i || time_init_i || time_updt_i)
      |=> !(time_rst_i || time_init_i || time_updt_i))
      else begin
         $error("time base pulse longer than one cycle");
         fail_cnt = fail_cnt + 1;
      end

endmodule

bind qnet_ctrl_top qnet_ctrl_assert u_assert (
   .t_clk_i      (t_clk_i),
   .ps_rst_ni    (ps_rst_ni),
   .c_cmd_i      (c_cmd_i),
   .c_ready_i    (c_ready_o),
   .time_rst_i   (time_rst_o),
   .time_init_i  (time_init_o),
   .time_updt_i  (time_updt_o),
   .core_start_i (core_start_o),
   .core_stop_i  (core_stop_o)
);

`default_nettype wire

//--- verif/qnet_ctrl_tb.sv
`include "qnet_settings.svh"
`default_nettype none

module qnet_ctrl_tb
   import qnet_pkg::*;
();

   localparam int READY_TIMEOUT = 2000;
   localparam int FIRE_TIMEOUT  = 2000;
   localparam int LATE_WATCH    = 200;    // Cycles with no core pulse allowed

   typedef enum int {K_PULSE, K_PARAM, K_FIRE, K_LATE} kind_e;

   logic                    t_clk;
   logic                    ps_rst_n;
   logic                    c_cmd;
   qnet_op_e                c_op;
   logic [`QNET_DATA_W-1:0] c_dt1;
   logic [`QNET_DATA_W-1:0] c_dt2;
   logic [`QNET_TIME_W-1:0] t_time;
   logic                    c_ready;
   logic                    time_rst;
   logic                    time_init;
   logic                    time_updt;
   logic [`QNET_DATA_W-1:0] time_off_dt;
   logic [`QNET_DATA_W-1:0] tnet_dt1;
   logic [`QNET_DATA_W-1:0] tnet_dt2;
   logic                    core_start;
   logic                    core_stop;
   logic [`QNET_ERR_W-1:0]  err_cnt;

   // Stimulus table kept as one queue per column
   string                   tbl_name[$];
   qnet_op_e                tbl_op[$];
   logic [`QNET_DATA_W-1:0] tbl_dt1[$];   // Signed margin for timed entries
   logic [`QNET_DATA_W-1:0] tbl_dt2[$];
   kind_e                   tbl_kind[$];
   logic [`QNET_DATA_W-1:0] tbl_exp[$];

   logic [15:0]             lfsr_q;
   // Expected parameter outputs
   logic [`QNET_DATA_W-1:0] m_off;
   logic [`QNET_DATA_W-1:0] m_dt1;
   logic [`QNET_DATA_W-1:0] m_dt2;

   qnet_ctrl_top dut0 (
      .t_clk_i        (t_clk),
      .ps_rst_ni      (ps_rst_n),
      .c_cmd_i        (c_cmd),
      .c_op_i         (c_op),
      .c_dt1_i        (c_dt1),
      .c_dt2_i        (c_dt2),
      .t_time_abs_i   (t_time),
      .c_ready_o      (c_ready),
      .time_rst_o     (time_rst),
      .time_init_o    (time_init),
      .time_updt_o    (time_updt),
      .time_off_dt_o  (time_off_dt),
      .tnet_dt1_o     (tnet_dt1),
      .tnet_dt2_o     (tnet_dt2),
      .core_start_o   (core_start),
      .core_stop_o    (core_stop),
      .ctrl_err_cnt_o (err_cnt)
   );

   initial begin
      t_clk = 1'b0;
      forever #4 t_clk = ~t_clk;
   end

   always @(posedge t_clk) begin
      t_time <= t_time + 1'b1;   // Free running absolute time
   end

   // Stop at the first bound assertion failure
   always @(negedge t_clk) begin
      if (dut0.u_assert.fail_cnt != 0) begin
         $display("a bound assertion on the DUT ports failed");
         $display("TEST FAILED");
         $fatal(1, "assertion failure");
      end
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] rand_word();
      logic [31:0] w;
      w = '0;
      for (int i = 0; i < 32; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         w      = {w[30:0], lfsr_q[0]};   // One step per bit
      end
      return w;
   endfunction

   task automatic check_value(input string tname, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
      if (exp_v !== act_v) begin
         $display("error %s expected %0h actual %0h", tname, exp_v, act_v);
         $display("TEST FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("TEST FAILED");
      $fatal(1, "wait loop expired");
   endtask

   task automatic add_entry(input string n, input qnet_op_e op, input logic [31:0] d1,
                            input logic [31:0] d2, input kind_e k, input logic [31:0] e);
      tbl_name.push_back(n);
      tbl_op.push_back(op);
      tbl_dt1.push_back(d1);
      tbl_dt2.push_back(d2);
      tbl_kind.push_back(k);
      tbl_exp.push_back(e);
   endtask

   task automatic build_table();
      logic [31:0] w;
      logic [3:0]  err_exp;
      err_exp = '0;
      w = rand_word();
      add_entry("set_off_a", OP_SET_OFF, w, rand_word(), K_PARAM, w);
      w = rand_word();
      add_entry("set_dt1_a", OP_SET_DT1, w, rand_word(), K_PARAM, w);
      w = rand_word();
      add_entry("set_dt2_a", OP_SET_DT2, w, rand_word(), K_PARAM, w);
      add_entry("set_rtd", OP_SET_RTD, 32'd100, rand_word(), K_PARAM, 32'd100);
      w = rand_word();
      add_entry("set_dt2_b", OP_SET_DT2, w, '0, K_PARAM, w);
      w = rand_word();
      add_entry("set_off_b", OP_SET_OFF, w, '0, K_PARAM, w);
      add_entry("time_rst", OP_TIME_RST, '0, '0, K_PULSE, 32'b100);
      add_entry("time_init", OP_TIME_INIT, '0, '0, K_PULSE, 32'b010);
      add_entry("time_updt", OP_TIME_UPDT, '0, '0, K_PULSE, 32'b001);
      add_entry("start_fire", OP_START_CORE, 32'd140, '0, K_FIRE, 32'b10);
      add_entry("stop_fire", OP_STOP_CORE, 32'd140, '0, K_FIRE, 32'b01);
      for (int i = 0; i < 17; i++) begin
         err_exp = (err_exp == 4'hf) ? err_exp : err_exp + 1'b1;
         // Entry 1 targets a time already past
         add_entry($sformatf("late_%0d", i), OP_START_CORE, (i == 1) ? -32'sd20 : 32'd5,
                   '0, K_LATE, err_exp);
      end
   endtask

   task automatic wait_ready(input string tname);
      int cycles;
      cycles = 0;
      @(negedge t_clk);
      while (!c_ready) begin
         cycles++;
         if (cycles > READY_TIMEOUT) begin
            report_timeout({"c_ready_o before ", tname});
         end
         @(negedge t_clk);
      end
   endtask

   //////////////////////////////////////////////////
   // Entry execution
   //////////////////////////////////////////////////
   task automatic apply_entry(input int idx);
      string                   n;
      logic [`QNET_TIME_W-1:0] target;
      int                      edge_n;
      int                      first;
      n = tbl_name[idx];
      wait_ready(n);
      target = t_time + {{(`QNET_TIME_W-`QNET_DATA_W){tbl_dt1[idx][31]}}, tbl_dt1[idx]};
      @(posedge t_clk);
      c_cmd <= 1'b1;
      c_op  <= tbl_op[idx];
      if (tbl_kind[idx] == K_FIRE || tbl_kind[idx] == K_LATE) begin
         c_dt1 <= target[`QNET_DATA_W-1:0];
         c_dt2 <= {{(2*`QNET_DATA_W-`QNET_TIME_W){1'b0}}, target[`QNET_TIME_W-1:`QNET_DATA_W]};
      end else begin
         c_dt1 <= tbl_dt1[idx];
         c_dt2 <= tbl_dt2[idx];
      end
      @(posedge t_clk);   // Edge 0 samples the strobe
      c_cmd <= 1'b0;
      case (tbl_kind[idx])
         K_PARAM: begin
            if (tbl_op[idx] == OP_SET_OFF) m_off = tbl_exp[idx];
            if (tbl_op[idx] == OP_SET_DT1) m_dt1 = tbl_exp[idx];
            if (tbl_op[idx] == OP_SET_DT2) m_dt2 = tbl_exp[idx];
            repeat (2) @(posedge t_clk);
            @(negedge t_clk);
            check_value({n, "_off"}, m_off, time_off_dt);
            check_value({n, "_dt1"}, m_dt1, tnet_dt1);
            check_value({n, "_dt2"}, m_dt2, tnet_dt2);
         end
         K_PULSE: begin
            @(negedge t_clk);
            check_value({n, "_before"}, 0, {time_rst, time_init, time_updt});
            @(negedge t_clk);
            check_value({n, "_pulse"}, tbl_exp[idx], {time_rst, time_init, time_updt});
            @(negedge t_clk);
            check_value({n, "_after"}, 0, {time_rst, time_init, time_updt});
         end
         K_FIRE: begin
            edge_n = 0;
            first  = -1;
            @(negedge t_clk);
            while ({core_start, core_stop} == 2'b00) begin
               if (first < 0 && t_time >= target) first = edge_n + 1;
               edge_n++;
               if (edge_n > FIRE_TIMEOUT) report_timeout({"core pulse of ", n});
               @(negedge t_clk);
            end
            check_value({n, "_which"}, tbl_exp[idx], {core_start, core_stop});
            check_value({n, "_not_early"}, 1, first >= 0);
            check_value({n, "_lag"}, 1, (edge_n - first >= 1) && (edge_n - first <= 3));
            @(negedge t_clk);
            check_value({n, "_width"}, 0, {core_start, core_stop});
            wait_ready(n);
         end
         default: begin
            edge_n = 0;
            @(negedge t_clk);
            while (!c_ready) begin
               edge_n++;
               if (edge_n > 4) report_timeout({"c_ready_o after late command ", n});
               @(negedge t_clk);
            end
            check_value({n, "_err_cnt"}, tbl_exp[idx], err_cnt);
            repeat (LATE_WATCH) begin
               @(negedge t_clk);
               check_value({n, "_no_core"}, 0, {core_start, core_stop});
            end
         end
      endcase
   endtask

   initial begin
      ps_rst_n = 1'b0;
      c_cmd    = 1'b0;
      c_op     = OP_NOP;
      c_dt1    = '0;
      c_dt2    = '0;
      t_time   = '0;
      lfsr_q   = 16'd65;
      m_off    = '0;
      m_dt1    = '0;
      m_dt2    = '0;
      build_table();
      repeat (16) @(posedge t_clk);
      ps_rst_n <= 1'b1;
      @(negedge t_clk);
      check_value("reset_ready", 1, c_ready);
      check_value("reset_pulses", 0, {time_rst, time_init, time_updt, core_start, core_stop});
      check_value("reset_params", 0, {time_off_dt, tnet_dt1});
      check_value("reset_dt2_err", 0, {tnet_dt2, err_cnt});
      for (int i = 0; i < tbl_name.size(); i++) begin
         apply_entry(i);
      end
      repeat (4) @(negedge t_clk);
      if (dut0.u_assert.fail_cnt != 0) begin
         $display("bound assertions failed %0d times", dut0.u_assert.fail_cnt);
         $display("TEST FAILED");
         $fatal(1, "assertion failures");
      end else begin
         $display("TEST OK");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
hw/qnet_pkg.sv
hw/qnet_cmd_decode.sv
hw/qnet_param_regs.sv
hw/qnet_ctrl_sched.sv
hw/qnet_ctrl_top.sv
verif/qnet_ctrl_assert.sv
verif/qnet_ctrl_tb.sv

//--- Bender.yml
package:
  name: qnet_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/qnet_pkg.sv
      - hw/qnet_cmd_decode.sv
      - hw/qnet_param_regs.sv
      - hw/qnet_ctrl_sched.sv
      - hw/qnet_ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/qnet_ctrl_assert.sv
      - verif/qnet_ctrl_tb.sv
